// ==== dlxCore.f ====
source/dlxPkg.sv
source/dlxControl.sv
source/dlxRegFile.sv
source/dlxExecute.sv
source/dlxFetch.sv
source/dlxCore.sv
verif/dlxChecker.sv
verif/dlxTb.sv

// ==== Makefile ====
# Verilator build and run for the dlxCore testbench.

VERILATOR ?= verilator
TOP       ?= dlxTb
FILELIST  ?= dlxCore.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST LOG OBJDIR FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verif/dlxTb.sv ====
module dlxTb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int numTests      = 20;
   localparam int progLen       = 40;
   localparam int dumpLen       = 31;
   localparam int haltIdx       = progLen + dumpLen;
   localparam int memWords      = 128;
   localparam int resetCycles   = 16;
   localparam int clkPeriod     = 10;
   localparam int cyclesPerTest = 2 * haltIdx + progLen;
   localparam int dumpBase      = 256;

   logic          Clk;
   logic          arstN;
   dlxPkg::instrT instr;
   dlxPkg::wordT  readData;
   dlxPkg::wordT  instrAddr;
   dlxPkg::wordT  dataAddr;
   dlxPkg::wordT  writeData;
   logic          dataWrite;
   logic          halted;

   dlxPkg::instrT progMem  [memWords];
   dlxPkg::wordT  dataMem  [memWords];
   dlxPkg::wordT  dataInit [memWords];
   logic [31:0]   rngState;

   dlxCore dut_i (
      .Clk       (Clk),
      .arstN     (arstN),
      .instr     (instr),
      .readData  (readData),
      .instrAddr (instrAddr),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .dataWrite (dataWrite),
      .halted    (halted)
   );

   dlxChecker chk_i (
      .Clk       (Clk),
      .arstN     (arstN),
      .instrAddr (instrAddr),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .dataWrite (dataWrite),
      .halted    (halted)
   );

   assign instr    = progMem[instrAddr[8:2]];
   assign readData = dataMem[dataAddr[8:2]];

   initial Clk = 1'b0;
   always #(clkPeriod / 2) Clk = ~Clk;

   always @(posedge Clk) begin
      if (dataWrite) begin
         dataMem[dataAddr[8:2]] = writeData;    // store taken at this edge.
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] nextRand();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   function automatic dlxPkg::funcT rFunc(input int k);
      case (k)
         0:       return dlxPkg::fnAdd;
         1:       return dlxPkg::fnSub;
         2:       return dlxPkg::fnAnd;
         3:       return dlxPkg::fnOr;
         4:       return dlxPkg::fnSll;
         default: return dlxPkg::fnSrl;
      endcase
   endfunction

   task automatic fillMemories();
      for (int a = 0; a < memWords; a++) begin
         progMem[a] = {dlxPkg::opHlt, 26'(a)};    // stray fetches halt.
         dataMem[a] = 32'(a);
      end
   endtask

   task automatic buildProgram();
      logic [31:0] r;
      logic [31:0] f;
      logic [31:0] g;
      logic [31:0] off;
      int          kind;
      fillMemories();
      for (int i = 0; i < progLen; i++) begin
         r    = nextRand();
         f    = nextRand();
         g    = nextRand();
         off  = (g % 32'(progLen - i)) << 2;    // forward and at most onto the dump.
         kind = int'(r % 32'd13);
         case (kind)
            6:  progMem[i] = {dlxPkg::opAddi, f[25:21], f[20:16], g[31:16]};
            7:  progMem[i] = {dlxPkg::opLw, 5'd0, f[20:16], 8'd0, g[5:0], 2'b00};
            8:  progMem[i] = {dlxPkg::opSw, 5'd0, f[20:16], 8'd0, g[5:0], 2'b00};
            9:  progMem[i] = {dlxPkg::opBeqz, f[25:21], 5'd0, off[15:0]};
            10: progMem[i] = {dlxPkg::opBnez, f[25:21], 5'd0, off[15:0]};
            11: progMem[i] = {dlxPkg::opJ, off[25:0]};
            12: progMem[i] = dlxPkg::instrNop;
            default: begin
               progMem[i] = {dlxPkg::opSpecial, f[25:21], f[20:16], f[15:11], 5'd0, rFunc(kind)};
            end
         endcase
      end
      for (int k = 1; k <= dumpLen; k++) begin
         progMem[progLen + k - 1] = {dlxPkg::opSw, 5'd0, 5'(k), 16'(dumpBase + 4 * k)};
      end
      progMem[haltIdx] = {dlxPkg::opHlt, 26'd0};
      for (int a = 0; a < memWords; a++) begin
         dataInit[a] = nextRand();
         dataMem[a]  = dataInit[a];
      end
   endtask

   // ISA interpreter that runs the program image to HLT.
   task automatic runModel(output logic done);
      dlxPkg::wordT   regs [32];
      dlxPkg::wordT   mem  [memWords];
      dlxPkg::instrT  ins;
      dlxPkg::wordT   a;
      dlxPkg::wordT   b;
      dlxPkg::wordT   immS;
      dlxPkg::wordT   addr;
      dlxPkg::wordT   pcAddr;
      dlxPkg::wordT   nextAddr;
      dlxPkg::wordT   val;
      dlxPkg::regIdxT dst;
      logic           wr;
      int             steps;
      for (int k = 0; k < 32; k++) regs[k] = '0;
      for (int k = 0; k < memWords; k++) mem[k] = dataInit[k];
      pcAddr = dlxPkg::resetPc;
      done   = 1'b0;
      steps  = 0;
      while (!done && steps < cyclesPerTest) begin
         ins      = progMem[pcAddr[8:2]];
         a        = regs[ins[25:21]];
         b        = regs[ins[20:16]];
         immS     = {{16{ins[15]}}, ins[15:0]};
         addr     = a + immS;
         nextAddr = pcAddr + 32'd4;
         wr       = 1'b0;
         dst      = ins[20:16];
         val      = '0;
         case (ins[31:26])
            dlxPkg::opSpecial: begin
               dst = ins[15:11];
               wr  = 1'b1;
               case (ins[5:0])
                  dlxPkg::fnAdd: val = a + b;
                  dlxPkg::fnSub: val = a - b;
                  dlxPkg::fnAnd: val = a & b;
                  dlxPkg::fnOr:  val = a | b;
                  dlxPkg::fnSll: val = a << b[4:0];
                  dlxPkg::fnSrl: val = a >> b[4:0];
                  default:       wr = 1'b0;
               endcase
            end
            dlxPkg::opAddi: begin
               wr  = 1'b1;
               val = addr;
            end
            dlxPkg::opLw: begin
               wr  = 1'b1;
               val = mem[addr[8:2]];
            end
            dlxPkg::opSw: begin
               mem[addr[8:2]] = b;
               chk_i.expectStore(addr, b);
            end
            dlxPkg::opBeqz: if (a == '0) nextAddr = nextAddr + immS;
            dlxPkg::opBnez: if (a != '0) nextAddr = nextAddr + immS;
            dlxPkg::opJ:    nextAddr = nextAddr + {{6{ins[25]}}, ins[25:0]};
            dlxPkg::opHlt:  done = 1'b1;
            default:        wr = 1'b0;
         endcase
         if (wr && dst != '0) regs[dst] = val;    // r0 stays zero.
         pcAddr = nextAddr;
         steps++;
      end
   endtask

   initial begin
      int   errBefore;
      int   testErrors;
      int   cycles;
      int   failedTests;
      int   otherFails;
      logic modelDone;
      arstN       = 1'b0;
      rngState    = 32'he76e;
      failedTests = 0;
      otherFails  = 0;
      fillMemories();
      for (int t = 0; t < numTests; t++) begin
         @(negedge Clk);
         arstN = 1'b0;
         buildProgram();
         chk_i.startTest();
         runModel(modelDone);
         errBefore = chk_i.errorCount;
         repeat (resetCycles) @(negedge Clk);
         arstN  = 1'b1;
         cycles = 0;
         while (!halted && cycles < cyclesPerTest) begin
            @(negedge Clk);
            cycles++;
         end
         repeat (4) @(negedge Clk);    // halted must hold with no late store.
         testErrors = chk_i.errorCount - errBefore;
         if (!modelDone) begin
            $display("program %0d: model did not reach HLT", t);
            testErrors++;
            otherFails++;
         end
         if (!halted) begin
            $display("program %0d: core did not halt within %0d cycles", t, cyclesPerTest);
            testErrors++;
            otherFails++;
         end
         if (testErrors == 0) begin
            $display("program %0d: ok, %0d stores in %0d cycles", t, chk_i.storeCount, cycles);
         end else begin
            $display("program %0d: failed with %0d errors", t, testErrors);
            failedTests++;
         end
      end
      $display("%0d programs, %0d passed, %0d failed, %0d errors", numTests,
               numTests - failedTests, failedTests, chk_i.errorCount + otherFails);
      if (failedTests == 0 && chk_i.errorCount == 0 && otherFails == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(numTests * cyclesPerTest * clkPeriod);
      $display("watchdog: run went past %0d ns and was stopped",
               numTests * cyclesPerTest * clkPeriod);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== verif/dlxChecker.sv ====
module dlxChecker (
   input logic         Clk,
   input logic         arstN,
   input dlxPkg::wordT instrAddr,
   input dlxPkg::wordT dataAddr,
   input dlxPkg::wordT writeData,
   input logic         dataWrite,
   input logic         halted
);

   timeunit 1ns;
   timeprecision 1ps;

   dlxPkg::wordT expAddrQ [$];
   dlxPkg::wordT expDataQ [$];
   int           errorCount = 0;
   int           storeCount = 0;
   int           expCount   = 0;
   logic         haltSeen   = 1'b0;
   logic         wasReset   = 1'b0;    // reset seen at the previous edge.

   task automatic startTest();
      expAddrQ.delete();
      expDataQ.delete();
      storeCount = 0;
      expCount   = 0;
      haltSeen   = 1'b0;
   endtask

   task automatic expectStore(input dlxPkg::wordT addr, input dlxPkg::wordT data);
      expAddrQ.push_back(addr);
      expDataQ.push_back(data);
      expCount++;
   endtask

   // outputs are read before the edge updates them.
   always @(posedge Clk) begin
      dlxPkg::wordT expAddr;
      dlxPkg::wordT expData;
      if (wasReset) begin
         if (dataWrite !== 1'b0 || halted !== 1'b0 || instrAddr !== dlxPkg::resetPc) begin
            $display("[ERROR] %0t: reset state dataWrite=%b halted=%b instrAddr=%h",
                     $time, dataWrite, halted, instrAddr);
            errorCount++;
         end
      end
      if (arstN) begin
         if (dataWrite) begin
            if (halted) begin
               $display("[ERROR] %0t: store to %h after halt", $time, dataAddr);
               errorCount++;
            end else if (expAddrQ.size() == 0) begin
               $display("[ERROR] %0t: unexpected store %h to %h", $time, writeData, dataAddr);
               errorCount++;
            end else begin
               expAddr = expAddrQ.pop_front();
               expData = expDataQ.pop_front();
               if (dataAddr !== expAddr || writeData !== expData) begin
                  $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
                           $time, storeCount, writeData, dataAddr, expData, expAddr);
                  errorCount++;
               end
            end
            storeCount++;
         end
         if (halted && !haltSeen) begin
            haltSeen = 1'b1;
            if (storeCount != expCount) begin
               $display("[ERROR] %0t: %0d stores before halt, expected %0d",
                        $time, storeCount, expCount);
               errorCount++;
            end
         end else if (haltSeen && !halted) begin
            $display("[ERROR] %0t: halted dropped without reset", $time);
            errorCount++;
         end
      end
      wasReset = !arstN;
   end

endmodule

// ==== source/dlxCore.sv ====
module dlxCore (
   input  logic          Clk,
   input  logic          arstN,
   input  dlxPkg::instrT instr,
   input  dlxPkg::wordT  readData,
   output dlxPkg::wordT  instrAddr,
   output dlxPkg::wordT  dataAddr,
   output dlxPkg::wordT  writeData,
   output logic          dataWrite,
   output logic          halted
);

   dlxPkg::instrT   ir;
   dlxPkg::wordT    pcNext;
   dlxPkg::exCtrlT  exCtrl;
   dlxPkg::memCtrlT memCtrl;
   dlxPkg::wbCtrlT  wbCtrl;
   logic            seSel;
   logic            isHalt;
   dlxPkg::wordT    rs1Data;
   dlxPkg::wordT    rs2Data;
   logic            regWe;
   dlxPkg::regIdxT  regWAddr;
   dlxPkg::wordT    regWData;
   logic            redirect;
   dlxPkg::wordT    target;

   dlxFetch uFetch (
      .Clk       (Clk),
      .arstN     (arstN),
      .instr     (instr),
      .redirect  (redirect),
      .target    (target),
      .isHalt    (isHalt),
      .instrAddr (instrAddr),
      .ir        (ir),
      .pcNext    (pcNext),
      .halted    (halted)
   );

   dlxControl uControl (
      .ir      (ir),
      .exCtrl  (exCtrl),
      .memCtrl (memCtrl),
      .wbCtrl  (wbCtrl),
      .seSel   (seSel),
      .isHalt  (isHalt)
   );

   dlxRegFile uRegFile (
      .Clk     (Clk),
      .arstN   (arstN),
      .rs1     (ir[25:21]),
      .rs2     (ir[20:16]),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .we      (regWe),
      .wAddr   (regWAddr),
      .wData   (regWData)
   );

   dlxExecute uExecute (
      .ir        (ir),
      .pcNext    (pcNext),
      .exCtrl    (exCtrl),
      .memCtrl   (memCtrl),
      .wbCtrl    (wbCtrl),
      .seSel     (seSel),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .readData  (readData),
      .regWe     (regWe),
      .regWAddr  (regWAddr),
      .regWData  (regWData),
      .redirect  (redirect),
      .target    (target),
      .dataAddr  (dataAddr),
      .dataWrite (dataWrite),
      .writeData (writeData)
   );

endmodule

// ==== source/dlxFetch.sv ====
module dlxFetch (
   input  logic          Clk,
   input  logic          arstN,
   input  dlxPkg::instrT instr,
   input  logic          redirect,
   input  dlxPkg::wordT  target,
   input  logic          isHalt,
   output dlxPkg::wordT  instrAddr,
   output dlxPkg::instrT ir,
   output dlxPkg::wordT  pcNext,
   output logic          halted
);

   typedef enum logic {
      fetchRun,
      fetchHalted
   } fetchStateT;

   fetchStateT   state;
   dlxPkg::wordT pc;
   dlxPkg::wordT pcInc;

   assign pcInc = pc + dlxPkg::pcStep;

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         state  <= fetchRun;
         pc     <= dlxPkg::resetPc;
         ir     <= dlxPkg::instrNop;
         pcNext <= dlxPkg::resetPc + dlxPkg::pcStep;
      end else if (state == fetchRun) begin
         if (isHalt) begin
            state <= fetchHalted;
            ir    <= dlxPkg::instrNop;    // pc freezes here.
         end else if (redirect) begin
            pc <= target;
            ir <= dlxPkg::instrNop;       // squash the wrong-path fetch.
         end else begin
            pc     <= pcInc;
            ir     <= instr;
            pcNext <= pcInc;
         end
      end
   end

   assign instrAddr = pc;
   assign halted    = (state == fetchHalted);

endmodule

// ==== source/dlxExecute.sv ====
module dlxExecute (
   input  dlxPkg::instrT   ir,
   input  dlxPkg::wordT    pcNext,
   input  dlxPkg::exCtrlT  exCtrl,
   input  dlxPkg::memCtrlT memCtrl,
   input  dlxPkg::wbCtrlT  wbCtrl,
   input  logic            seSel,
   input  dlxPkg::wordT    rs1Data,
   input  dlxPkg::wordT    rs2Data,
   input  dlxPkg::wordT    readData,
   output logic            regWe,
   output dlxPkg::regIdxT  regWAddr,
   output dlxPkg::wordT    regWData,
   output logic            redirect,
   output dlxPkg::wordT    target,
   output dlxPkg::wordT    dataAddr,
   output logic            dataWrite,
   output dlxPkg::wordT    writeData
);

   dlxPkg::exClassT exClass;
   dlxPkg::aluOpT   aluOp;
   dlxPkg::wordT    imm;
   dlxPkg::wordT    opB;
   dlxPkg::wordT    aluResult;
   logic            rs1Zero;
   logic            condMet;

   assign exClass = exCtrl[dlxPkg::clsW+dlxPkg::aluOpW-1:dlxPkg::aluOpW];
   assign aluOp   = exCtrl[dlxPkg::aluOpW-1:0];

   assign imm = seSel ? {{6{ir[25]}}, ir[25:0]} : {{16{ir[15]}}, ir[15:0]};
   assign opB = (exClass == dlxPkg::clsRType) ? rs2Data : imm;

   always_comb begin
      case (aluOp)
         dlxPkg::aluSub: aluResult = rs1Data - opB;
         dlxPkg::aluAnd: aluResult = rs1Data & opB;
         dlxPkg::aluOr:  aluResult = rs1Data | opB;
         dlxPkg::aluSll: aluResult = rs1Data << rs2Data[4:0];
         dlxPkg::aluSrl: aluResult = rs1Data >> rs2Data[4:0];
         default:        aluResult = rs1Data + opB;    // add and address sums.
      endcase
   end

   // branch condition only looks at rs1.
   assign rs1Zero = (rs1Data == '0);

   always_comb begin
      case (aluOp)
         dlxPkg::aluTestZ:  condMet = rs1Zero;
         dlxPkg::aluTestNz: condMet = !rs1Zero;
         default:           condMet = 1'b0;
      endcase
   end

   assign target   = pcNext + imm;
   assign redirect = memCtrl[dlxPkg::memJumpBit]
                     | (memCtrl[dlxPkg::memBranchBit] & condMet);

   assign dataAddr  = aluResult;
   assign dataWrite = memCtrl[dlxPkg::memStoreBit];    // one-cycle store strobe.
   assign writeData = rs2Data;

   assign regWe    = wbCtrl[dlxPkg::wbRegWriteBit];
   assign regWAddr = wbCtrl[dlxPkg::wbDestIsRdBit] ? ir[15:11] : ir[20:16];
   assign regWData = wbCtrl[dlxPkg::wbFromAluBit] ? aluResult : readData;

endmodule

// ==== source/dlxRegFile.sv ====
module dlxRegFile (
   input  logic           Clk,
   input  logic           arstN,
   input  dlxPkg::regIdxT rs1,
   input  dlxPkg::regIdxT rs2,
   output dlxPkg::wordT   rs1Data,
   output dlxPkg::wordT   rs2Data,
   input  logic           we,
   input  dlxPkg::regIdxT wAddr,
   input  dlxPkg::wordT   wData
);

   dlxPkg::wordT regs [dlxPkg::regCount];

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < dlxPkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wAddr != '0)) begin    // r0 ignores writes.
         regs[wAddr] <= wData;
      end
   end

   assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/dlxControl.sv ====
module dlxControl (
   input  dlxPkg::instrT   ir,
   output dlxPkg::exCtrlT  exCtrl,
   output dlxPkg::memCtrlT memCtrl,
   output dlxPkg::wbCtrlT  wbCtrl,
   output logic            seSel,
   output logic            isHalt
);

   dlxPkg::opcodeT opcode;
   dlxPkg::funcT   func;

   assign opcode = ir[31:26];
   assign func   = ir[5:0];

   assign seSel  = (opcode == dlxPkg::opJ);     // 26-bit offset for J.
   assign isHalt = (opcode == dlxPkg::opHlt);

   always_comb begin
      exCtrl  = '0;
      memCtrl = dlxPkg::memNone;
      wbCtrl  = dlxPkg::wbNone;
      case (opcode)
         dlxPkg::opSpecial: begin
            case (func)
               dlxPkg::fnSll: begin
                  exCtrl = {dlxPkg::clsRType, dlxPkg::aluSll};
                  wbCtrl = dlxPkg::wbAluRd;
               end
               dlxPkg::fnSrl: begin
                  exCtrl = {dlxPkg::clsRType, dlxPkg::aluSrl};
                  wbCtrl = dlxPkg::wbAluRd;
               end
               dlxPkg::fnAdd: begin
                  exCtrl = {dlxPkg::clsRType, dlxPkg::aluAdd};
                  wbCtrl = dlxPkg::wbAluRd;
               end
               dlxPkg::fnSub: begin
                  exCtrl = {dlxPkg::clsRType, dlxPkg::aluSub};
                  wbCtrl = dlxPkg::wbAluRd;
               end
               dlxPkg::fnAnd: begin
                  exCtrl = {dlxPkg::clsRType, dlxPkg::aluAnd};
                  wbCtrl = dlxPkg::wbAluRd;
               end
               dlxPkg::fnOr: begin
                  exCtrl = {dlxPkg::clsRType, dlxPkg::aluOr};
                  wbCtrl = dlxPkg::wbAluRd;
               end
               default: begin
                  exCtrl = '0;    // NOP and unknown func.
               end
            endcase
         end
         dlxPkg::opJ: begin
            exCtrl  = {dlxPkg::clsBranch, dlxPkg::aluTarget};
            memCtrl = dlxPkg::memJump;
         end
         dlxPkg::opBeqz: begin
            exCtrl  = {dlxPkg::clsBranch, dlxPkg::aluTestZ};
            memCtrl = dlxPkg::memBranch;
         end
         dlxPkg::opBnez: begin
            exCtrl  = {dlxPkg::clsBranch, dlxPkg::aluTestNz};
            memCtrl = dlxPkg::memBranch;
         end
         dlxPkg::opAddi: begin
            exCtrl = {dlxPkg::clsIType, dlxPkg::aluAdd};
            wbCtrl = dlxPkg::wbAluRt;
         end
         dlxPkg::opLw: begin
            exCtrl = {dlxPkg::clsMemAcc, dlxPkg::aluAdd};
            wbCtrl = dlxPkg::wbLoad;
         end
         dlxPkg::opSw: begin
            exCtrl  = {dlxPkg::clsMemAcc, dlxPkg::aluAdd};
            memCtrl = dlxPkg::memStore;
         end
         default: begin
            // HLT and unknown opcodes decode as NOP.
            exCtrl = '0;
         end
      endcase
   end

endmodule

// ==== source/dlxPkg.sv ====
package dlxPkg;

   localparam int wordW    = 32;
   localparam int regIdxW  = 5;
   localparam int regCount = 32;
   localparam int opW      = 6;
   localparam int funcW    = 6;
   localparam int aluOpW   = 3;
   localparam int clsW     = 2;
   localparam int memCtrlW = 3;
   localparam int wbCtrlW  = 3;

   typedef logic [wordW-1:0]          wordT;
   typedef logic [wordW-1:0]          instrT;
   typedef logic [regIdxW-1:0]        regIdxT;
   typedef logic [opW-1:0]            opcodeT;
   typedef logic [funcW-1:0]          funcT;
   typedef logic [aluOpW-1:0]         aluOpT;
   typedef logic [clsW-1:0]           exClassT;
   typedef logic [clsW+aluOpW-1:0]    exCtrlT;    // {exClass, aluOp}.
   typedef logic [memCtrlW-1:0]       memCtrlT;
   typedef logic [wbCtrlW-1:0]        wbCtrlT;

   localparam opcodeT opSpecial = 6'h00;
   localparam opcodeT opJ       = 6'h02;
   localparam opcodeT opBeqz    = 6'h04;
   localparam opcodeT opBnez    = 6'h05;
   localparam opcodeT opAddi    = 6'h08;
   localparam opcodeT opLw      = 6'h23;
   localparam opcodeT opSw      = 6'h2B;
   localparam opcodeT opHlt     = 6'h3F;

   localparam funcT fnSll = 6'h04;
   localparam funcT fnSrl = 6'h06;
   localparam funcT fnAdd = 6'h20;
   localparam funcT fnSub = 6'h22;
   localparam funcT fnAnd = 6'h24;
   localparam funcT fnOr  = 6'h25;

   localparam exClassT clsRType  = 2'b00;
   localparam exClassT clsIType  = 2'b01;
   localparam exClassT clsBranch = 2'b10;
   localparam exClassT clsMemAcc = 2'b11;

   localparam aluOpT aluAdd    = 3'd0;
   localparam aluOpT aluSub    = 3'd1;
   localparam aluOpT aluAnd    = 3'd2;
   localparam aluOpT aluOr     = 3'd3;
   localparam aluOpT aluSll    = 3'd4;
   localparam aluOpT aluSrl    = 3'd5;
   localparam aluOpT aluTestZ  = 3'd6;
   localparam aluOpT aluTestNz = 3'd7;
   localparam aluOpT aluTarget = 3'd0;    // only meaningful under clsBranch.

   // memCtrl bits are {store, jump, branch}.
   localparam int memStoreBit  = 2;
   localparam int memJumpBit   = 1;
   localparam int memBranchBit = 0;
   localparam memCtrlT memNone   = 3'b000;
   localparam memCtrlT memStore  = 3'b100;
   localparam memCtrlT memJump   = 3'b010;
   localparam memCtrlT memBranch = 3'b001;

   // wbCtrl bits are {regWrite, destIsRd, fromAlu}.
   localparam int wbRegWriteBit = 2;
   localparam int wbDestIsRdBit = 1;
   localparam int wbFromAluBit  = 0;
   localparam wbCtrlT wbNone  = 3'b000;
   localparam wbCtrlT wbAluRd = 3'b111;
   localparam wbCtrlT wbAluRt = 3'b101;
   localparam wbCtrlT wbLoad  = 3'b100;

   localparam instrT instrNop = '0;
   localparam wordT  resetPc  = '0;
   localparam wordT  pcStep   = 32'd4;

endpackage
